// File: verilog.f
hdl/audio_pkg.sv
hdl/mix_pkg.sv
hdl/sample_fetch.sv
hdl/chan_timer.sv
hdl/chan_mixer.sv
hdl/pdm_dac.sv
hdl/audio_mixer_top.sv
tb/tb_clock.sv
tb/audio_mixer_asserts.sv
tb/audio_mixer_tb.sv

// File: Bender.yml
package:
  name: audio_mixer

sources:
  - files:
      - hdl/audio_pkg.sv
      - hdl/mix_pkg.sv
      - hdl/sample_fetch.sv
      - hdl/chan_timer.sv
      - hdl/chan_mixer.sv
      - hdl/pdm_dac.sv
      - hdl/audio_mixer_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/audio_mixer_asserts.sv
      - tb/audio_mixer_tb.sv

// File: tb/audio_mixer_tb.sv
// audio mixer testbench: random samples and volumes, memory responder and reference model
`timescale 1ns/100ps

module audio_mixer_tb import audio_pkg::*, mix_pkg::*; ();

    localparam int CLK_NS      = 10;
    localparam int RESET_CYC   = 16;
    localparam int WINDOW      = 256;                   // density measurement length
    localparam int SETTLE      = 300;                   // stale words flushed by then
    localparam int IDLE_SETTLE = 40;
    localparam int MIX_PHASES  = 4;                     // random mixing phases
    localparam int PHASE_CYC   = SETTLE + WINDOW;
    localparam int RUN_CYC     = RESET_CYC + 2 * (IDLE_SETTLE + WINDOW)
                               + (MIX_PHASES + 3) * PHASE_CYC;
    localparam int MARGIN_CYC  = 1000;

    logic                       clk;
    logic                       reset_i;
    logic                       audio_enable_i;
    logic [16*AUDIO_NCHAN-1:0]  start_nchan_i;
    logic [16*AUDIO_NCHAN-1:0]  length_nchan_i;
    logic [15*AUDIO_NCHAN-1:0]  period_nchan_i;
    logic [7*AUDIO_NCHAN-1:0]   vol_l_nchan_i;
    logic [7*AUDIO_NCHAN-1:0]   vol_r_nchan_i;
    logic                       audio_ack_i;
    word_t                      audio_word_i;
    logic                       audio_req_o;
    addr_t                      audio_addr_o;
    logic                       pdm_l_o;
    logic                       pdm_r_o;

    logic [31:0]    lcg_state;
    sample_t        phase_sample [AUDIO_NCHAN];         // both bytes of every word
    int             exp_off [AUDIO_NCHAN];              // model offset from start
    logic           exp_restart [AUDIO_NCHAN];          // model next request from start
    int             fetched [AUDIO_NCHAN];              // words acked per channel
    logic           req_seen;                           // delay already drawn
    int             ack_wait;                           // cycles left before ack
    int             count_l;                            // high cycles in window
    int             count_r;
    int             error_count;

    tb_clock #(.PERIOD_NS(CLK_NS)) tb_clock_i (.clk(clk));

    audio_mixer_top audio_mixer_top_i (.*);

    bind audio_mixer_top audio_mixer_asserts asserts_i (
        .clk(clk), .reset_i(reset_i), .enable_i(audio_enable_i), .req_i(audio_req_o),
        .addr_i(audio_addr_o), .ack_i(audio_ack_i),
        .fetch_state_i(sample_fetch_i.fetch_state)
    );

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]) % n;              // upper bits, better spread
    endfunction

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input int got, input int exp, input int tol);
        if (got < exp - tol || got > exp + tol) begin
            stop_on_error($sformatf("[ERROR] %0t %s got %0d expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    // clamped sum of sample times volume, then offset binary
    function automatic int model_level(input logic [7*AUDIO_NCHAN-1:0] vols);
        int sum;
        int mix;
        sum = 0;
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            sum += int'(phase_sample[c]) * int'(vols[7*c +: 7]);
        end
        mix = sum >>> MIX_SHIFT;
        if (mix > 127) begin
            mix = 127;
        end else if (mix < -128) begin
            mix = -128;
        end
        return mix + 128;
    endfunction

    // channel found from the address region, then the model walk
    task automatic accept_request();
        int ch;
        ch = int'(audio_addr_o[15:12]) - 1;
        if (ch < 0 || ch >= AUDIO_NCHAN) begin
            stop_on_error("request address lies outside every channel's range");
        end else begin
            if (exp_restart[ch] || exp_off[ch] == int'(length_nchan_i[16*ch +: 16])) begin
                exp_off[ch] = 0;                        // back to start
            end else begin
                exp_off[ch]++;
            end
            exp_restart[ch] = 1'b0;
            check_val("audio_addr_o", int'(audio_addr_o),
                      int'(start_nchan_i[16*ch +: 16]) + exp_off[ch], 0);
            fetched[ch]++;
            audio_word_i = {phase_sample[ch], phase_sample[ch]};
            audio_ack_i  = 1'b1;
            req_seen     = 1'b0;
        end
    endtask

    // memory side, one call per falling edge
    task automatic respond();
        if (audio_ack_i) begin
            audio_ack_i = 1'b0;                         // single cycle ack
        end else if (audio_req_o && audio_enable_i) begin
            if (!req_seen) begin
                req_seen = 1'b1;
                ack_wait = rand_below(6);               // 0 to 5 cycles
            end
            if (ack_wait == 0) begin
                accept_request();
            end else begin
                ack_wait--;
            end
        end else begin
            req_seen = 1'b0;                            // dropped by a disable
        end
    endtask

    task automatic tick(input int n);
        repeat (n) begin
            @(negedge clk);
            respond();
            if (reset_i) begin
                check_val("pdm_l_o", pdm_l_o, 0, 0);
                check_val("pdm_r_o", pdm_r_o, 0, 0);
            end
            if (!audio_enable_i) begin
                check_val("audio_req_o", audio_req_o, 0, 0);    // enable was low at last edge
            end
            count_l += pdm_l_o;
            count_r += pdm_r_o;
        end
    endtask

    task automatic measure_density(input int exp_l, input int exp_r);
        count_l = 0;
        count_r = 0;
        tick(WINDOW);
        check_val("pdm_l_o density", count_l, exp_l, 2);
        check_val("pdm_r_o density", count_r, exp_r, 2);
    endtask

    // disabled mixer sees zero samples, midscale level
    task automatic idle_phase();
        audio_enable_i = 1'b0;
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            exp_restart[c] = 1'b1;
        end
        tick(IDLE_SETTLE);
        measure_density(128, 128);
    endtask

    // kind 0 random, 1 loud positive, 2 loud negative
    task automatic mix_phase(input int kind);
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            case (kind)
                0: phase_sample[c] = sample_t'(rand_below(256) - 128);
                1: phase_sample[c] = sample_t'(100 + rand_below(28));
                default: phase_sample[c] = sample_t'(-128 + rand_below(28));
            endcase
            vol_l_nchan_i[7*c +: 7] = (kind == 0) ? vol_t'(rand_below(32)) : 7'd127;
            vol_r_nchan_i[7*c +: 7] = (kind == 0) ? vol_t'(rand_below(32)) : 7'd127;
        end
        tick(SETTLE);
        measure_density(model_level(vol_l_nchan_i), model_level(vol_r_nchan_i));
    endtask

    initial begin
        lcg_state      = 32'd39;
        error_count    = 0;
        reset_i        = 1'b1;
        audio_enable_i = 1'b0;
        audio_ack_i    = 1'b0;
        audio_word_i   = '0;
        req_seen       = 1'b0;
        ack_wait       = 0;
        vol_l_nchan_i  = '0;
        vol_r_nchan_i  = '0;
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            start_nchan_i[16*c +: 16]  = 16'h1000 * (c + 1) + rand_below(16);  // own 4K region
            length_nchan_i[16*c +: 16] = rand_below(4);                         // short, wraps often
            period_nchan_i[15*c +: 15] = rand_below(8);
            phase_sample[c] = '0;
            exp_off[c]      = 0;
            exp_restart[c]  = 1'b1;
            fetched[c]      = 0;
        end
        tick(RESET_CYC);
        reset_i = 1'b0;
        idle_phase();
        audio_enable_i = 1'b1;
        repeat (MIX_PHASES) mix_phase(0);
        mix_phase(1);
        mix_phase(2);
        idle_phase();                                   // disable pulse, restart from start
        audio_enable_i = 1'b1;
        mix_phase(0);
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            if (fetched[c] < 3 * (int'(length_nchan_i[16*c +: 16]) + 1)) begin
                stop_on_error($sformatf("channel %0d fetched too few words to wrap", c));
            end
        end
        if (error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "errors were found");
        end
    end

    initial begin
        #(CLK_NS * (RUN_CYC + MARGIN_CYC));
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: tb/audio_mixer_asserts.sv
// audio mixer assertions on the memory handshake and the enable input
`timescale 1ns/100ps

module audio_mixer_asserts import audio_pkg::*; (
    input logic         clk,
    input logic         reset_i,
    input logic         enable_i,           // audio enable at the top level
    input logic         req_i,              // memory request
    input addr_t        addr_i,
    input logic         ack_i,
    input fetch_state_t fetch_state_i       // fetch FSM state
);

    // held until acked, a disable may abandon it
    req_held: assert property (@(posedge clk) disable iff (reset_i)
        (req_i && !ack_i && enable_i) |=> (req_i && $stable(addr_i)))
        else $error("request or address changed before the acknowledge");

    req_drop: assert property (@(posedge clk) disable iff (reset_i)
        $fell(enable_i) |=> !req_i)
        else $error("request still high one cycle after the enable fell");

    fsm_parked: assert property (@(posedge clk) disable iff (reset_i)
        !enable_i |=> fetch_state_i == FETCH_CHECK)
        else $error("fetch FSM left the check state while disabled");

endmodule

// File: tb/tb_clock.sv
// testbench clock source, free running square wave
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 10                // full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                             // first rising edge at half a period
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// File: hdl/audio_mixer_top.sv
// audio mixer top: sample fetch, channel timers, stereo mixer and two PDM DACs
`timescale 1ns/100ps

module audio_mixer_top import audio_pkg::*, mix_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        audio_enable_i,
    input  logic [16*AUDIO_NCHAN-1:0]   start_nchan_i,
    input  logic [16*AUDIO_NCHAN-1:0]   length_nchan_i,
    input  logic [15*AUDIO_NCHAN-1:0]   period_nchan_i,
    input  logic [7*AUDIO_NCHAN-1:0]    vol_l_nchan_i,
    input  logic [7*AUDIO_NCHAN-1:0]    vol_r_nchan_i,
    input  logic                        audio_ack_i,
    input  word_t                       audio_word_i,
    output logic                        audio_req_o,
    output addr_t                       audio_addr_o,
    output logic                        pdm_l_o,
    output logic                        pdm_r_o
);

    logic                       word_valid;     // fetched word strobe
    chan_t                      word_chan;
    word_t                      word;
    logic [AUDIO_NCHAN-1:0]     need_word;      // empty buffers
    logic [8*AUDIO_NCHAN-1:0]   sample_nchan;   // bytes now playing
    dac_t                       level_l;        // mixed levels
    dac_t                       level_r;

    sample_fetch sample_fetch_i (
        .clk(clk), .reset_i(reset_i), .audio_enable_i(audio_enable_i),
        .start_nchan_i(start_nchan_i), .length_nchan_i(length_nchan_i),
        .need_word_i(need_word), .audio_ack_i(audio_ack_i), .audio_word_i(audio_word_i),
        .audio_req_o(audio_req_o), .audio_addr_o(audio_addr_o),
        .word_valid_o(word_valid), .word_chan_o(word_chan), .word_o(word)
    );

    chan_timer chan_timer_i (
        .clk(clk), .reset_i(reset_i), .audio_enable_i(audio_enable_i),
        .period_nchan_i(period_nchan_i), .word_valid_i(word_valid),
        .word_chan_i(word_chan), .word_i(word),
        .need_word_o(need_word), .sample_nchan_o(sample_nchan)
    );

    chan_mixer chan_mixer_i (
        .clk(clk), .reset_i(reset_i), .sample_nchan_i(sample_nchan),
        .vol_l_nchan_i(vol_l_nchan_i), .vol_r_nchan_i(vol_r_nchan_i),
        .level_l_o(level_l), .level_r_o(level_r)
    );

    pdm_dac #(.WIDTH(DAC_W)) pdm_l_i (
        .clk(clk), .reset_i(reset_i), .value_i(level_l), .pulse_o(pdm_l_o)
    );

    pdm_dac #(.WIDTH(DAC_W)) pdm_r_i (
        .clk(clk), .reset_i(reset_i), .value_i(level_r), .pulse_o(pdm_r_o)
    );

endmodule

// File: hdl/pdm_dac.sv
// pdm DAC: first-order pulse density modulator for one output pin
`timescale 1ns/100ps

module pdm_dac import mix_pkg::*; #(
    parameter int WIDTH = DAC_W                 // level bits
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [WIDTH-1:0]    value_i,        // unsigned level
    output logic                pulse_o         // high value_i times in 2**WIDTH
);

    logic [WIDTH:0] pdm_acc;                    // error plus carry

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pdm_acc <= '0;
        end else begin
            pdm_acc <= pdm_acc[WIDTH-1:0] + value_i;    // carry out is the pulse
        end
    end

    assign pulse_o = pdm_acc[WIDTH];

endmodule

// File: hdl/chan_mixer.sv
// channel mixer: scans channels, stereo multiply-accumulate, clamps to unsigned DAC levels
`timescale 1ns/100ps

module chan_mixer import audio_pkg::*, mix_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [8*AUDIO_NCHAN-1:0]    sample_nchan_i,     // signed byte per channel
    input  logic [7*AUDIO_NCHAN-1:0]    vol_l_nchan_i,      // left volume per channel
    input  logic [7*AUDIO_NCHAN-1:0]    vol_r_nchan_i,      // right volume per channel
    output dac_t                        level_l_o,          // once per frame
    output dac_t                        level_r_o
);

    logic [CHAN_W:0]    mix_chan;       // extra step clamps and clears
    logic               mix_last;       // clamp step of the frame
    sample_t            value_temp;     // latched channel sample
    vol_t               vol_l_temp;
    vol_t               vol_r_temp;
    acc_t               res_l;          // product of latched channel
    acc_t               res_r;
    acc_t               acc_l;
    acc_t               acc_r;

    // add that pins at the rails instead of wrapping
    function automatic acc_t sat_add(acc_t a, acc_t b);
        logic signed [$bits(acc_t):0] sum;
        sum = a + b;
        if (sum[$bits(acc_t)] != sum[$bits(acc_t)-1]) begin
            return {sum[$bits(acc_t)], {($bits(acc_t)-1){~sum[$bits(acc_t)]}}};
        end
        return acc_t'(sum);
    endfunction

    // drop low bits, clamp to a signed byte, flip sign for offset binary
    function automatic dac_t to_level(acc_t acc);
        mix_t mix;
        mix = acc[$bits(acc_t)-1:MIX_SHIFT];
        if (mix < -(2**(DAC_W-1))) begin
            return '0;
        end else if (mix > 2**(DAC_W-1)-1) begin
            return '1;
        end
        return {~mix[DAC_W-1], mix[DAC_W-2:0]};
    endfunction

    assign mix_last = (mix_chan == AUDIO_NCHAN);
    assign res_l    = value_temp * $signed({1'b0, vol_l_temp});    // volume zero-extended
    assign res_r    = value_temp * $signed({1'b0, vol_r_temp});

    always_ff @(posedge clk) begin
        if (!mix_last) begin
            value_temp <= sample_nchan_i[8*mix_chan[CHAN_W-1:0] +: 8];
            vol_l_temp <= vol_l_nchan_i[7*mix_chan[CHAN_W-1:0] +: 7];
            vol_r_temp <= vol_r_nchan_i[7*mix_chan[CHAN_W-1:0] +: 7];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_chan  <= '0;
            acc_l     <= '0;
            acc_r     <= '0;
            level_l_o <= '0;
            level_r_o <= '0;
        end else if (mix_last) begin
            mix_chan  <= '0;
            level_l_o <= to_level(sat_add(acc_l, res_l));      // last channel folded in here
            level_r_o <= to_level(sat_add(acc_r, res_r));
            acc_l     <= '0;
            acc_r     <= '0;
        end else begin
            mix_chan <= mix_chan + 1'b1;
            if (mix_chan != '0) begin                           // product of previous channel
                acc_l <= sat_add(acc_l, res_l);
                acc_r <= sat_add(acc_r, res_r);
            end
        end
    end

endmodule

// File: hdl/chan_timer.sv
// channel timers: per-channel word buffers and period counters picking the byte to play
`timescale 1ns/100ps

module chan_timer import audio_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        audio_enable_i,     // low silences and empties all
    input  logic [15*AUDIO_NCHAN-1:0]   period_nchan_i,     // clocks per byte minus two
    input  logic                        word_valid_i,       // fetched word strobe
    input  chan_t                       word_chan_i,
    input  word_t                       word_i,
    output logic [AUDIO_NCHAN-1:0]      need_word_o,        // buffer empty, per channel
    output logic [8*AUDIO_NCHAN-1:0]    sample_nchan_o      // signed byte now playing
);

    word_t                      chan_buff [AUDIO_NCHAN];    // fetched sample word
    logic [AUDIO_NCHAN-1:0]     chan_buff_ok;               // buffer holds an unplayed word
    logic [AUDIO_NCHAN-1:0]     chan_odd;                   // low byte is next
    logic [15:0]                chan_count [AUDIO_NCHAN];   // bit 15 set on underflow
    period_t                    chan_period [AUDIO_NCHAN];  // per-channel period slice

    always_comb begin
        for (int i = 0; i < AUDIO_NCHAN; i++) begin
            chan_period[i] = period_nchan_i[15*i +: 15];
        end
    end

    assign need_word_o = ~chan_buff_ok;

    always_ff @(posedge clk) begin
        if (reset_i || !audio_enable_i) begin
            chan_buff_ok   <= '0;                               // every buffer empty
            chan_odd       <= '0;                               // restart on high byte
            sample_nchan_o <= '0;                               // silence
            for (int i = 0; i < AUDIO_NCHAN; i++) begin
                chan_count[i] <= 16'h8000;                      // underflow right away
                if (reset_i) begin
                    chan_buff[i] <= '0;                         // stale bytes start as zero
                end
            end
        end else begin
            for (int i = 0; i < AUDIO_NCHAN; i++) begin
                chan_count[i] <= chan_count[i] - 1'b1;
                if (chan_count[i][15]) begin
                    chan_count[i]          <= {1'b0, chan_period[i]};
                    chan_odd[i]            <= ~chan_odd[i];
                    sample_nchan_o[8*i +: 8] <= chan_odd[i] ? chan_buff[i][7:0]
                                                            : chan_buff[i][15:8];
                    if (chan_odd[i]) begin
                        chan_buff_ok[i] <= 1'b0;                // both bytes played
                    end
                end
            end
            if (word_valid_i) begin
                chan_buff[word_chan_i]    <= word_i;
                chan_buff_ok[word_chan_i] <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/sample_fetch.sv
// sample fetch: walks each channel's word range and reads words over request/acknowledge
`timescale 1ns/100ps

module sample_fetch import audio_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        audio_enable_i,     // low restarts every channel
    input  logic [16*AUDIO_NCHAN-1:0]   start_nchan_i,      // first word address per channel
    input  logic [16*AUDIO_NCHAN-1:0]   length_nchan_i,     // word count minus one
    input  logic [AUDIO_NCHAN-1:0]      need_word_i,        // buffer empty, per channel
    input  logic                        audio_ack_i,        // memory done, word valid
    input  word_t                       audio_word_i,
    output logic                        audio_req_o,        // held until ack
    output addr_t                       audio_addr_o,       // held with request
    output logic                        word_valid_o,       // strobe in ack cycle
    output chan_t                       word_chan_o,        // channel the word belongs to
    output word_t                       word_o
);

    fetch_state_t               fetch_state;                // FSM state
    chan_t                      fetch_chan;                 // channel being served
    logic [AUDIO_NCHAN-1:0]     fetch_restart;              // next request from start
    addr_t                      fetch_ptr [AUDIO_NCHAN];    // next word address
    word_t                      fetch_cnt [AUDIO_NCHAN];    // words left before wrap
    logic                       reload;                     // restart or count exhausted
    addr_t                      req_addr;                   // address for this request

    // start over on restart or when the count ran out
    always_comb begin
        reload   = fetch_restart[fetch_chan] || (fetch_cnt[fetch_chan] == '0);
        req_addr = reload ? start_nchan_i[16*fetch_chan +: 16]
                          : fetch_ptr[fetch_chan];
    end

    // pointer and count of the channel being requested
    always_ff @(posedge clk) begin
        if (fetch_state == FETCH_REQ) begin
            fetch_ptr[fetch_chan] <= req_addr + 1'b1;               // word after this one
            fetch_cnt[fetch_chan] <= reload ? length_nchan_i[16*fetch_chan +: 16]
                                            : fetch_cnt[fetch_chan] - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_state   <= FETCH_CHECK;
            fetch_chan    <= '0;
            fetch_restart <= '1;                                    // all channels from start
            audio_req_o   <= 1'b0;
            audio_addr_o  <= '0;
        end else if (!audio_enable_i) begin
            fetch_state   <= FETCH_CHECK;                           // park on channel 0
            fetch_chan    <= '0;
            fetch_restart <= '1;
            audio_req_o   <= 1'b0;                                  // abandon pending request
        end else begin
            case (fetch_state)
                FETCH_CHECK: begin
                    if (need_word_i[fetch_chan]) begin
                        fetch_state <= FETCH_REQ;
                    end else begin
                        fetch_state <= FETCH_NEXT;                  // buffer still full
                    end
                end
                FETCH_REQ: begin
                    audio_req_o               <= 1'b1;
                    audio_addr_o              <= req_addr;
                    fetch_restart[fetch_chan] <= 1'b0;
                    fetch_state               <= FETCH_WAIT_ACK;
                end
                FETCH_WAIT_ACK: begin
                    if (audio_ack_i) begin
                        audio_req_o <= 1'b0;                        // drops on next edge
                        fetch_state <= FETCH_NEXT;
                    end
                end
                FETCH_NEXT: begin
                    fetch_chan  <= fetch_chan + 1'b1;               // wraps after last channel
                    fetch_state <= FETCH_CHECK;
                end
                default: begin
                    fetch_state <= FETCH_CHECK;
                end
            endcase
        end
    end

    // word handed to the channel timers as it is acknowledged
    assign word_valid_o = (fetch_state == FETCH_WAIT_ACK) && audio_ack_i;
    assign word_chan_o  = fetch_chan;
    assign word_o       = audio_word_i;

endmodule

// File: hdl/mix_pkg.sv
// mix package: sample, volume, accumulator and DAC types with mix scaling
package mix_pkg;

    localparam int DAC_W     = 8;               // DAC level bits
    localparam int MIX_SHIFT = 6;               // low accumulator bits dropped

    typedef logic signed [7:0]       sample_t;  // signed channel sample
    typedef logic [6:0]              vol_t;     // unsigned volume
    typedef logic signed [15:0]      acc_t;     // stereo side accumulator
    typedef logic signed [9:0]       mix_t;     // unclamped mix, acc upper bits
    typedef logic [DAC_W-1:0]        dac_t;     // unsigned DAC level

endpackage

// File: hdl/audio_pkg.sv
// audio fetch package: channel count, memory-side types and the fetch FSM states
package audio_pkg;

    localparam int AUDIO_NCHAN = 4;             // mixed channels
    localparam int CHAN_W      = 2;             // bits to index one channel

    typedef logic [CHAN_W-1:0] chan_t;          // channel index
    typedef logic [15:0]       word_t;          // memory word, two 8-bit samples
    typedef logic [15:0]       addr_t;          // sample word address
    typedef logic [14:0]       period_t;        // playback period in clocks

    // sample fetch FSM, one channel visited per pass
    typedef enum logic [1:0] {
        FETCH_CHECK,                            // does this channel need a word
        FETCH_REQ,                              // pick address, raise request
        FETCH_WAIT_ACK,                         // hold request until ack
        FETCH_NEXT                              // step to next channel
    } fetch_state_t;

endpackage
